//--- logic/sms_pkg.sv
package sms_pkg;

  // ============================================================
  // Bus types
  // ============================================================
  typedef logic [7:0]  byte_t;
  typedef logic [15:0] cpu_addr_t;
  typedef logic [13:0] vdp_addr_t;   // VRAM address and table bases
  typedef logic [21:0] rom_addr_t;   // Slot byte plus 14-bit offset
  typedef logic [2:0]  vdp_mode_t;   // Display mode 0 to 4

  // ============================================================
  // I/O ports
  // ============================================================
  // Encoded as {address[7:6], address[0]}
  typedef enum logic [2:0] {
    port_mem_ctrl  = 3'd0,
    port_joy_ctrl  = 3'd1,
    port_v_counter = 3'd2,
    port_psg       = 3'd3,  // Also H counter on read
    port_vdp_data  = 3'd4,
    port_vdp_ctrl  = 3'd5,
    port_joy_a     = 3'd6,
    port_joy_b     = 3'd7
  } io_port_e;

  // ============================================================
  // Register constants
  // ============================================================
  localparam int vdp_reg_count = 11;

  localparam byte_t mem_ctrl_reset = 8'hf7;  // BIOS enabled

  // Mapper registers at the top of RAM
  localparam cpu_addr_t mapper_misc_addr  = 16'hfffc;
  localparam cpu_addr_t mapper_slot0_addr = 16'hfffd;
  localparam cpu_addr_t mapper_slot1_addr = 16'hfffe;
  localparam cpu_addr_t mapper_slot2_addr = 16'hffff;

  // Status low field with no sprite overflow
  localparam logic [4:0] no_sprite5 = 5'h1f;

endpackage

//--- logic/sms_bus_decode.sv
`timescale 1ns/1ns

module sms_bus_decode (
  input  logic                 cpuClock,
  input  logic                 n_hard_reset,
  input  logic                 i_cpu_clk_en,
  input  sms_pkg::cpu_addr_t   i_address,
  input  logic                 i_n_rd,
  input  logic                 i_n_wr,
  input  logic                 i_n_mreq,
  input  logic                 i_n_iorq,
  output logic                 o_cpu_edge,
  output logic                 o_io_rd,
  output logic                 o_io_wr,
  output logic                 o_mem_rd,
  output logic                 o_mem_wr,
  output sms_pkg::io_port_e    o_io_port
);

  logic r_clk_en_d;  // Enable seen last cycle

  // ============================================================
  // CPU edge strobe
  // ============================================================
  always_ff @(posedge cpuClock) begin
    if (!n_hard_reset) begin
      r_clk_en_d <= 1'b0;
    end else begin
      r_clk_en_d <= i_cpu_clk_en;
    end
  end

  // One cycle wide on each rising enable
  assign o_cpu_edge = i_cpu_clk_en && !r_clk_en_d;

  // ============================================================
  // Cycle qualification
  // ============================================================
  assign o_io_rd  = !i_n_iorq && !i_n_rd;
  assign o_io_wr  = !i_n_iorq && !i_n_wr;
  assign o_mem_rd = !i_n_mreq && !i_n_rd;
  assign o_mem_wr = !i_n_mreq && !i_n_wr;

  // Port pairs from bits 7:6, bit 0 picks within the pair
  assign o_io_port = sms_pkg::io_port_e'({i_address[7:6], i_address[0]});

  // The CPU never runs an I/O and a memory cycle at once
  a_io_mem_exclusive: assert property (
    @(posedge cpuClock) disable iff (!n_hard_reset)
    !((o_io_rd || o_io_wr) && (o_mem_rd || o_mem_wr))
  );

endmodule

//--- logic/sms_vdp_port.sv
`timescale 1ns/1ns

module sms_vdp_port (
  input  logic                 cpuClock,
  input  logic                 n_hard_reset,
  input  logic                 i_cpu_edge,
  input  logic                 i_io_rd,
  input  logic                 i_io_wr,
  input  sms_pkg::io_port_e    i_io_port,
  input  sms_pkg::byte_t       i_data,
  output sms_pkg::vdp_addr_t   o_vdp_addr,
  output logic                 o_vdp_wr,
  output logic                 o_vdp_rd,
  output logic                 o_cram_selected,
  output sms_pkg::vdp_mode_t   o_mode,
  output sms_pkg::vdp_addr_t   o_name_table_addr,
  output sms_pkg::vdp_addr_t   o_color_table_addr,
  output sms_pkg::vdp_addr_t   o_pattern_addr,
  output sms_pkg::vdp_addr_t   o_sprite_attr_addr,
  output sms_pkg::vdp_addr_t   o_sprite_pattern_addr,
  output sms_pkg::byte_t       o_x_scroll,
  output sms_pkg::byte_t       o_y_scroll,
  output sms_pkg::byte_t       o_line_counter,
  output logic [3:0]           o_overscan_color,
  output logic                 o_video_on,
  output logic                 o_frame_irq_en
);

  sms_pkg::byte_t     r_vdp [sms_pkg::vdp_reg_count];
  sms_pkg::byte_t     r_first_byte;   // Latched first control byte
  logic               r_second_byte;
  logic               r_data_rd_d;    // Data read seen at last edge
  sms_pkg::vdp_addr_t r_addr;
  logic               r_cram;

  logic data_wr, data_rd, ctrl_wr, ctrl_rd;
  logic m1, m2, m3, m4;

  assign data_wr = i_io_wr && i_io_port == sms_pkg::port_vdp_data;
  assign data_rd = i_io_rd && i_io_port == sms_pkg::port_vdp_data;
  assign ctrl_wr = i_io_wr && i_io_port == sms_pkg::port_vdp_ctrl;
  assign ctrl_rd = i_io_rd && i_io_port == sms_pkg::port_vdp_ctrl;

  assign o_vdp_wr = data_wr && i_cpu_edge;
  assign o_vdp_rd = data_rd && i_cpu_edge;

  // ============================================================
  // Control port and address counter
  // ============================================================
  always_ff @(posedge cpuClock) begin
    if (!n_hard_reset) begin
      r_second_byte <= 1'b0;
      r_data_rd_d   <= 1'b0;
      r_cram        <= 1'b0;
      r_addr        <= '0;
      for (int i = 0; i < sms_pkg::vdp_reg_count; i++) r_vdp[i] <= '0;
    end else if (i_cpu_edge) begin
      r_data_rd_d <= data_rd;
      if (data_wr) r_addr <= r_addr + 1'b1;
      if (r_data_rd_d && !data_rd) r_addr <= r_addr + 1'b1;  // After the read ends

      if (ctrl_rd || data_rd || data_wr) r_second_byte <= 1'b0;

      if (ctrl_wr) begin
        r_second_byte <= !r_second_byte;
        if (!r_second_byte) begin
          r_first_byte <= i_data;
        end else if (!i_data[7]) begin
          r_addr <= {i_data[5:0], r_first_byte};  // VRAM, bit 6 ignored
          r_cram <= 1'b0;
        end else if (i_data[6] == 1'b0 && i_data[3:0] < sms_pkg::vdp_reg_count) begin
          r_vdp[i_data[3:0]] <= r_first_byte;
        end else begin
          // CRAM, also for out of range registers
          r_addr <= {8'd0, r_first_byte[5:0]};
          r_cram <= 1'b1;
        end
      end
    end
  end

  assign o_vdp_addr      = r_addr;
  assign o_cram_selected = r_cram;

  // ============================================================
  // Decoded register fields
  // ============================================================
  assign m1 = r_vdp[1][4];
  assign m2 = r_vdp[0][1];
  assign m3 = r_vdp[1][3];
  assign m4 = r_vdp[0][2];

  assign o_mode = m4 ? 3'd4 : m3 ? 3'd3 : m2 ? 3'd2 : m1 ? 3'd1 : 3'd0;

  assign o_name_table_addr  = {r_vdp[2][3:1], 11'd0};
  assign o_color_table_addr = (o_mode == 3'd2) ? {r_vdp[3][7], 13'd0} : {r_vdp[3], 6'd0};
  assign o_pattern_addr     = (o_mode == 3'd4) ? 14'd0 :
                              (o_mode == 3'd2) ? {r_vdp[4][2], 13'd0} :
                                                 {r_vdp[4][2:0], 11'd0};
  assign o_sprite_attr_addr    = {r_vdp[5][6:1], 8'd0};
  assign o_sprite_pattern_addr = (o_mode == 3'd4) ? {r_vdp[6][2], 13'd0} :
                                                    {r_vdp[6][2:0], 11'd0};

  assign o_overscan_color = r_vdp[7][3:0];
  assign o_x_scroll       = r_vdp[8];
  assign o_y_scroll       = r_vdp[9];
  assign o_line_counter   = r_vdp[10];
  assign o_video_on       = r_vdp[1][6];
  assign o_frame_irq_en   = r_vdp[1][5];  // Vertical retrace interrupt

  a_no_rd_wr_overlap: assert property (
    @(posedge cpuClock) disable iff (!n_hard_reset)
    !(o_vdp_wr && o_vdp_rd)
  );

endmodule

//--- logic/sms_mapper.sv
`timescale 1ns/1ns

module sms_mapper #(
  parameter int ram_addr_bits = 13
) (
  input  logic                     cpuClock,
  input  logic                     n_hard_reset,
  input  logic                     i_cpu_edge,
  input  logic                     i_mem_wr,
  input  logic                     i_io_wr,
  input  sms_pkg::io_port_e        i_io_port,
  input  sms_pkg::cpu_addr_t       i_address,
  input  sms_pkg::byte_t           i_data,
  output sms_pkg::rom_addr_t       o_rom_addr,
  output logic [ram_addr_bits-1:0] o_ram_addr,
  output logic                     o_ram_we,
  output logic                     o_bios_selected,
  output logic                     o_psg_we
);

  sms_pkg::byte_t r_mem_ctrl;
  sms_pkg::byte_t r_misc;
  sms_pkg::byte_t r_slot0, r_slot1, r_slot2;
  sms_pkg::byte_t bank;

  // ============================================================
  // Mapper registers
  // ============================================================
  always_ff @(posedge cpuClock) begin
    if (!n_hard_reset) begin
      r_mem_ctrl <= sms_pkg::mem_ctrl_reset;
      r_misc     <= '0;
      r_slot0    <= 8'd0;
      r_slot1    <= 8'd1;
      r_slot2    <= 8'd2;
    end else if (i_cpu_edge) begin
      if (i_io_wr && i_io_port == sms_pkg::port_mem_ctrl) r_mem_ctrl <= i_data;
      if (i_mem_wr) begin
        case (i_address)
          sms_pkg::mapper_misc_addr:  r_misc  <= i_data;
          sms_pkg::mapper_slot0_addr: r_slot0 <= i_data;
          sms_pkg::mapper_slot1_addr: r_slot1 <= i_data;
          sms_pkg::mapper_slot2_addr: r_slot2 <= i_data;
          default: ;
        endcase
      end
    end
  end

  // Slot by quarter, top quarter is RAM and maps to itself
  always_comb begin
    case (i_address[15:14])
      2'd0:    bank = r_slot0;
      2'd1:    bank = r_slot1;
      2'd2:    bank = r_slot2;
      default: bank = 8'd3;
    endcase
  end

  assign o_rom_addr = {bank + {6'd0, r_misc[1:0]}, i_address[13:0]};  // Bank shift from FFFC

  assign o_ram_addr      = i_address[ram_addr_bits-1:0];  // Mirrored over C000-FFFF
  assign o_ram_we        = i_mem_wr && i_address[15:14] == 2'b11;
  assign o_bios_selected = !r_mem_ctrl[3];
  assign o_psg_we        = i_cpu_edge && i_io_wr && i_io_port == sms_pkg::port_psg;

  // One PSG write per CPU write cycle
  a_psg_we_single: assert property (
    @(posedge cpuClock) disable iff (!n_hard_reset)
    o_psg_we |=> !o_psg_we
  );

endmodule

//--- logic/sms_read_mux.sv
`timescale 1ns/1ns

module sms_read_mux (
  input  logic                 cpuClock,
  input  logic                 n_hard_reset,
  input  logic                 i_cpu_edge,
  input  logic                 i_io_rd,
  input  logic                 i_mem_rd,
  input  sms_pkg::io_port_e    i_io_port,
  input  sms_pkg::cpu_addr_t   i_address,
  input  logic                 i_bios_selected,
  input  sms_pkg::byte_t       i_bios_data,
  input  sms_pkg::byte_t       i_rom_data,
  input  sms_pkg::byte_t       i_ram_data,
  input  sms_pkg::byte_t       i_vdp_rdata,
  input  sms_pkg::byte_t       i_v_counter,
  input  sms_pkg::byte_t       i_h_counter,
  input  logic [5:0]           i_buttons,
  input  logic                 i_frame_irq,
  input  logic                 i_sprite_collision,
  input  logic                 i_too_many_sprites,
  input  logic [4:0]           i_sprite5,
  output sms_pkg::byte_t       o_cpu_data_in
);

  logic           r_frame_flag;
  logic           r_collision_flag;
  logic           r_status_rd_d;
  logic           status_rd;
  sms_pkg::byte_t status;
  sms_pkg::byte_t joy_data;

  assign status_rd = i_io_rd && i_io_port == sms_pkg::port_vdp_ctrl;

  // ============================================================
  // Sticky status flags
  // ============================================================
  always_ff @(posedge cpuClock) begin
    if (!n_hard_reset) begin
      r_frame_flag     <= 1'b0;
      r_collision_flag <= 1'b0;
      r_status_rd_d    <= 1'b0;
    end else begin
      if (i_frame_irq) r_frame_flag <= 1'b1;
      if (i_sprite_collision) r_collision_flag <= 1'b1;
      if (i_cpu_edge) begin
        r_status_rd_d <= status_rd;
        if (r_status_rd_d && !status_rd) begin  // Status read just ended
          r_frame_flag     <= 1'b0;
          r_collision_flag <= 1'b0;
        end
      end
    end
  end

  assign status = {r_frame_flag, i_too_many_sprites, r_collision_flag,
                   i_too_many_sprites ? i_sprite5 : sms_pkg::no_sprite5};

  assign joy_data = {2'b00, ~i_buttons};  // Buttons read active low

  // ============================================================
  // Read data select
  // ============================================================
  always_comb begin
    o_cpu_data_in = i_ram_data;
    if (i_io_rd && i_io_port == sms_pkg::port_vdp_data) begin
      o_cpu_data_in = i_vdp_rdata;
    end else if (status_rd) begin
      o_cpu_data_in = status;
    end else if (i_io_rd && (i_io_port == sms_pkg::port_joy_a ||
                             i_io_port == sms_pkg::port_joy_b)) begin
      o_cpu_data_in = joy_data;
    end else if (i_io_rd && i_io_port == sms_pkg::port_v_counter) begin
      o_cpu_data_in = i_v_counter;
    end else if (i_io_rd && i_io_port == sms_pkg::port_psg) begin
      o_cpu_data_in = i_h_counter;
    end else if (i_mem_rd && i_address[15:14] != 2'b11) begin
      o_cpu_data_in = i_bios_selected ? i_bios_data : i_rom_data;
    end
  end

  // Every status read spans at least one CPU edge
  a_status_rd_seen: assert property (
    @(posedge cpuClock) disable iff (!n_hard_reset)
    $fell(status_rd) |-> r_status_rd_d
  );

endmodule

//--- logic/sms_bus_top.sv
`timescale 1ns/1ns

module sms_bus_top #(
  parameter int ram_addr_bits = 13
) (
  input  logic                     cpuClock,
  input  logic                     n_hard_reset,
  input  logic                     i_cpu_clk_en,
  input  sms_pkg::cpu_addr_t       i_address,
  input  logic                     i_n_rd,
  input  logic                     i_n_wr,
  input  logic                     i_n_mreq,
  input  logic                     i_n_iorq,
  input  sms_pkg::byte_t           i_data,
  input  sms_pkg::byte_t           i_bios_data,
  input  sms_pkg::byte_t           i_rom_data,
  input  sms_pkg::byte_t           i_ram_data,
  input  sms_pkg::byte_t           i_vdp_rdata,
  input  sms_pkg::byte_t           i_v_counter,
  input  sms_pkg::byte_t           i_h_counter,
  input  logic [5:0]               i_buttons,
  input  logic                     i_frame_irq,
  input  logic                     i_sprite_collision,
  input  logic                     i_too_many_sprites,
  input  logic [4:0]               i_sprite5,
  output sms_pkg::vdp_addr_t       o_vdp_addr,
  output logic                     o_vdp_wr,
  output logic                     o_vdp_rd,
  output logic                     o_cram_selected,
  output sms_pkg::vdp_mode_t       o_mode,
  output sms_pkg::vdp_addr_t       o_name_table_addr,
  output sms_pkg::vdp_addr_t       o_color_table_addr,
  output sms_pkg::vdp_addr_t       o_pattern_addr,
  output sms_pkg::vdp_addr_t       o_sprite_attr_addr,
  output sms_pkg::vdp_addr_t       o_sprite_pattern_addr,
  output sms_pkg::byte_t           o_x_scroll,
  output sms_pkg::byte_t           o_y_scroll,
  output sms_pkg::byte_t           o_line_counter,
  output logic [3:0]               o_overscan_color,
  output logic                     o_video_on,
  output logic                     o_frame_irq_en,
  output sms_pkg::rom_addr_t       o_rom_addr,
  output logic [ram_addr_bits-1:0] o_ram_addr,
  output logic                     o_ram_we,
  output logic                     o_psg_we,
  output sms_pkg::byte_t           o_cpu_data_in
);

  logic              cpu_edge;
  logic              io_rd, io_wr, mem_rd, mem_wr;
  sms_pkg::io_port_e io_port;
  logic              bios_selected;

  sms_bus_decode u_decode (
    .cpuClock, .n_hard_reset, .i_cpu_clk_en, .i_address,
    .i_n_rd, .i_n_wr, .i_n_mreq, .i_n_iorq,
    .o_cpu_edge(cpu_edge), .o_io_rd(io_rd), .o_io_wr(io_wr),
    .o_mem_rd(mem_rd), .o_mem_wr(mem_wr), .o_io_port(io_port)
  );

  sms_vdp_port u_vdp_port (
    .cpuClock, .n_hard_reset, .i_cpu_edge(cpu_edge), .i_io_rd(io_rd), .i_io_wr(io_wr),
    .i_io_port(io_port), .i_data, .o_vdp_addr, .o_vdp_wr, .o_vdp_rd, .o_cram_selected,
    .o_mode, .o_name_table_addr, .o_color_table_addr, .o_pattern_addr,
    .o_sprite_attr_addr, .o_sprite_pattern_addr, .o_x_scroll, .o_y_scroll,
    .o_line_counter, .o_overscan_color, .o_video_on, .o_frame_irq_en
  );

  sms_mapper #(.ram_addr_bits(ram_addr_bits)) u_mapper (
    .cpuClock, .n_hard_reset, .i_cpu_edge(cpu_edge), .i_mem_wr(mem_wr), .i_io_wr(io_wr),
    .i_io_port(io_port), .i_address, .i_data, .o_rom_addr, .o_ram_addr, .o_ram_we,
    .o_bios_selected(bios_selected), .o_psg_we
  );

  sms_read_mux u_read_mux (
    .cpuClock, .n_hard_reset, .i_cpu_edge(cpu_edge), .i_io_rd(io_rd), .i_mem_rd(mem_rd),
    .i_io_port(io_port), .i_address, .i_bios_selected(bios_selected), .i_bios_data,
    .i_rom_data, .i_ram_data, .i_vdp_rdata, .i_v_counter, .i_h_counter, .i_buttons,
    .i_frame_irq, .i_sprite_collision, .i_too_many_sprites, .i_sprite5, .o_cpu_data_in
  );

endmodule

//--- verification/sms_bus_tb.sv
`timescale 1ns/1ns

module sms_bus_tb;

  localparam int ram_bits = 13;

  typedef enum {op_idle, op_io_wr, op_io_rd, op_mem_wr, op_mem_rd} bus_op_e;
  typedef enum {chk_none, chk_data, chk_vaddr, chk_rom, chk_mode, chk_name, chk_xscroll,
                chk_cram, chk_ram, chk_color, chk_pattern, chk_sattr, chk_spat, chk_yscroll,
                chk_line, chk_overscan, chk_video_on, chk_irq_en} chk_e;

  typedef struct {
    bus_op_e            op;
    sms_pkg::cpu_addr_t addr;
    sms_pkg::byte_t     data;
    logic               irq;   // Frame and collision pulse for the whole row
    chk_e               chk;
    logic [31:0]        exp;
    logic [3:0]         strb;  // Edge cycle {ram_we, psg_we, vdp_rd, vdp_wr}
  } row_t;

  logic                 cpuClock = 1'b0;
  logic                 n_hard_reset;
  logic                 i_cpu_clk_en = 1'b0;
  sms_pkg::cpu_addr_t   i_address;
  logic                 i_n_rd, i_n_wr, i_n_mreq, i_n_iorq;
  sms_pkg::byte_t       i_data, i_bios_data, i_rom_data, i_ram_data, i_vdp_rdata;
  sms_pkg::byte_t       i_v_counter, i_h_counter;
  logic [5:0]           i_buttons;
  logic                 i_frame_irq, i_sprite_collision, i_too_many_sprites;
  logic [4:0]           i_sprite5;
  sms_pkg::vdp_addr_t   o_vdp_addr, o_name_table_addr, o_color_table_addr, o_pattern_addr;
  sms_pkg::vdp_addr_t   o_sprite_attr_addr, o_sprite_pattern_addr;
  logic                 o_vdp_wr, o_vdp_rd, o_cram_selected, o_video_on, o_frame_irq_en;
  logic                 o_ram_we, o_psg_we;
  sms_pkg::vdp_mode_t   o_mode;
  sms_pkg::byte_t       o_x_scroll, o_y_scroll, o_line_counter, o_cpu_data_in;
  logic [3:0]           o_overscan_color;
  sms_pkg::rom_addr_t   o_rom_addr;
  logic [ram_bits-1:0]  o_ram_addr;

  logic [2:0] en_phase = 3'd0;  // Position in the 7-cycle enable period
  row_t       rows[$];
  int         row_idx;

  sms_bus_top #(.ram_addr_bits(ram_bits)) dut_i (.*);

  always #4 cpuClock = ~cpuClock;

  // CPU enable, high for 3 of every 7 cycles
  always @(posedge cpuClock) begin
    if (!n_hard_reset) begin
      en_phase     <= 3'd0;
      i_cpu_clk_en <= 1'b0;
    end else begin
      en_phase     <= (en_phase == 3'd6) ? 3'd0 : en_phase + 3'd1;
      i_cpu_clk_en <= (en_phase == 3'd6) || (en_phase < 3'd2);
    end
  end

  // ============================================================
  // Expected values
  // ============================================================
  function automatic logic [31:0] rom_expect(sms_pkg::byte_t slot, sms_pkg::cpu_addr_t a);
    return {10'd0, slot, a[13:0]};
  endfunction

  // Too-many-sprites held low, so bit 6 is clear and the low field shows no overflow
  function automatic logic [31:0] status_expect(logic frame, logic coll);
    return {24'd0, frame, 1'b0, coll, sms_pkg::no_sprite5};
  endfunction

  task automatic add_row(bus_op_e op, sms_pkg::cpu_addr_t addr, sms_pkg::byte_t data,
                         logic irq, chk_e chk, logic [31:0] exp,
                         logic [3:0] strb = 4'b0000);
    rows.push_back('{op, addr, data, irq, chk, exp, strb});
  endtask

  task automatic build_table();
    // Reset slots 0, 1, 2 then new slot bytes
    add_row(op_mem_rd, 16'h0123, 8'h00, 1'b0, chk_rom, rom_expect(8'd0, 16'h0123));
    add_row(op_mem_rd, 16'h4567, 8'h00, 1'b0, chk_rom, rom_expect(8'd1, 16'h4567));
    add_row(op_mem_rd, 16'h89ab, 8'h00, 1'b0, chk_rom, rom_expect(8'd2, 16'h89ab));
    add_row(op_mem_wr, 16'hfffd, 8'h05, 1'b0, chk_none, 0, 4'b1000);
    add_row(op_mem_wr, 16'hfffe, 8'h11, 1'b0, chk_none, 0, 4'b1000);
    add_row(op_mem_wr, 16'hffff, 8'h3c, 1'b0, chk_none, 0, 4'b1000);
    add_row(op_mem_rd, 16'h0123, 8'h00, 1'b0, chk_rom, rom_expect(8'h05, 16'h0123));
    add_row(op_mem_rd, 16'h7fff, 8'h00, 1'b0, chk_rom, rom_expect(8'h11, 16'h7fff));
    add_row(op_mem_rd, 16'hbeef, 8'h00, 1'b0, chk_rom, rom_expect(8'h3c, 16'hbeef));
    // VRAM address load and auto increment
    add_row(op_io_wr, 16'h00bf, 8'h34, 1'b0, chk_none, 0);
    add_row(op_io_wr, 16'h00bf, 8'h12, 1'b0, chk_vaddr, 'h1234);
    add_row(op_io_wr, 16'h00be, 8'haa, 1'b0, chk_vaddr, 'h1235, 4'b0001);
    add_row(op_io_wr, 16'h00be, 8'hbb, 1'b0, chk_vaddr, 'h1236, 4'b0001);
    add_row(op_io_rd, 16'h00be, 8'h00, 1'b0, chk_data, 32'(i_vdp_rdata), 4'b0010);
    add_row(op_idle, 16'h0000, 8'h00, 1'b0, chk_vaddr, 'h1237);  // Moves after the read
    // Register writes, M4 beats M1
    add_row(op_io_wr, 16'h00bf, 8'h04, 1'b0, chk_none, 0);
    add_row(op_io_wr, 16'h00bf, 8'h80, 1'b0, chk_mode, 4);
    add_row(op_io_wr, 16'h00bf, 8'h10, 1'b0, chk_none, 0);
    add_row(op_io_wr, 16'h00bf, 8'h81, 1'b0, chk_mode, 4);
    add_row(op_io_wr, 16'h00bf, 8'h00, 1'b0, chk_none, 0);
    add_row(op_io_wr, 16'h00bf, 8'h80, 1'b0, chk_mode, 1);
    add_row(op_io_wr, 16'h00bf, 8'h0e, 1'b0, chk_none, 0);
    add_row(op_io_wr, 16'h00bf, 8'h82, 1'b0, chk_name, 'h3800);
    add_row(op_io_wr, 16'h00bf, 8'h5a, 1'b0, chk_none, 0);
    add_row(op_io_wr, 16'h00bf, 8'h88, 1'b0, chk_xscroll, 'h5a);
    add_row(op_io_wr, 16'h00bf, 8'h77, 1'b0, chk_none, 0);
    add_row(op_io_wr, 16'h00bf, 8'h8b, 1'b0, chk_vaddr, 'h37);   // No register 11
    add_row(op_idle, 16'h0000, 8'h00, 1'b0, chk_cram, 1);
    // Table bases, scroll and flags in mode 1
    add_row(op_io_wr, 16'h00bf, 8'h2c, 1'b0, chk_none, 0);
    add_row(op_io_wr, 16'h00bf, 8'h83, 1'b0, chk_color, 'h0b00);
    add_row(op_io_wr, 16'h00bf, 8'h05, 1'b0, chk_none, 0);
    add_row(op_io_wr, 16'h00bf, 8'h84, 1'b0, chk_pattern, 'h2800);
    add_row(op_io_wr, 16'h00bf, 8'h7e, 1'b0, chk_none, 0);
    add_row(op_io_wr, 16'h00bf, 8'h85, 1'b0, chk_sattr, 'h3f00);
    add_row(op_io_wr, 16'h00bf, 8'h03, 1'b0, chk_none, 0);
    add_row(op_io_wr, 16'h00bf, 8'h86, 1'b0, chk_spat, 'h1800);
    add_row(op_io_wr, 16'h00bf, 8'hf9, 1'b0, chk_none, 0);
    add_row(op_io_wr, 16'h00bf, 8'h87, 1'b0, chk_overscan, 'h9);
    add_row(op_io_wr, 16'h00bf, 8'hc3, 1'b0, chk_none, 0);
    add_row(op_io_wr, 16'h00bf, 8'h89, 1'b0, chk_yscroll, 'hc3);
    add_row(op_io_wr, 16'h00bf, 8'h42, 1'b0, chk_none, 0);
    add_row(op_io_wr, 16'h00bf, 8'h8a, 1'b0, chk_line, 'h42);
    add_row(op_io_wr, 16'h00bf, 8'h70, 1'b0, chk_none, 0);
    add_row(op_io_wr, 16'h00bf, 8'h81, 1'b0, chk_video_on, 1);
    add_row(op_idle, 16'h0000, 8'h00, 1'b0, chk_irq_en, 1);
    // CRAM select and release
    add_row(op_io_wr, 16'h00bf, 8'h00, 1'b0, chk_none, 0);
    add_row(op_io_wr, 16'h00bf, 8'h01, 1'b0, chk_cram, 0);
    add_row(op_io_wr, 16'h00bf, 8'h25, 1'b0, chk_none, 0);
    add_row(op_io_wr, 16'h00bf, 8'hc0, 1'b0, chk_cram, 1);
    add_row(op_idle, 16'h0000, 8'h00, 1'b0, chk_vaddr, 'h25);
    // Read sources
    add_row(op_io_rd, 16'h007e, 8'h00, 1'b0, chk_data, 32'(i_v_counter));
    add_row(op_io_rd, 16'h007f, 8'h00, 1'b0, chk_data, 32'(i_h_counter));
    add_row(op_io_wr, 16'h007f, 8'h9f, 1'b0, chk_none, 0, 4'b0100);  // PSG write
    add_row(op_io_rd, 16'h00dc, 8'h00, 1'b0, chk_data, 32'({2'b00, ~i_buttons}));
    add_row(op_io_rd, 16'h00dd, 8'h00, 1'b0, chk_data, 32'({2'b00, ~i_buttons}));
    add_row(op_io_rd, 16'h00bf, 8'h00, 1'b0, chk_data, status_expect(1'b0, 1'b0));
    add_row(op_mem_rd, 16'hc123, 8'h00, 1'b0, chk_data, 32'(i_ram_data));
    add_row(op_mem_wr, 16'hd456, 8'h00, 1'b0, chk_ram, 'h1456, 4'b1000);  // 8 KB mirror
    add_row(op_mem_rd, 16'h2345, 8'h00, 1'b0, chk_data, 32'(i_bios_data));
    add_row(op_io_wr, 16'h003e, 8'hab, 1'b0, chk_none, 0);       // BIOS off
    add_row(op_mem_rd, 16'h2345, 8'h00, 1'b0, chk_data, 32'(i_rom_data));
    // Sticky flags
    add_row(op_idle, 16'h0000, 8'h00, 1'b1, chk_none, 0);
    add_row(op_io_rd, 16'h00bf, 8'h00, 1'b0, chk_data, status_expect(1'b1, 1'b1));
    add_row(op_idle, 16'h0000, 8'h00, 1'b0, chk_none, 0);
    add_row(op_io_rd, 16'h00bf, 8'h00, 1'b0, chk_data, status_expect(1'b0, 1'b0));
  endtask

  // ============================================================
  // Bus driving and checks
  // ============================================================
  task automatic stop_on_error();
    $display("TEST FAILED");
    $fatal(1, "Stopped at table row %0d", row_idx);
  endtask

  task automatic drive_bus(row_t r);
    i_address          <= r.addr;
    i_data             <= r.data;
    i_n_rd             <= !(r.op == op_io_rd || r.op == op_mem_rd);
    i_n_wr             <= !(r.op == op_io_wr || r.op == op_mem_wr);
    i_n_iorq           <= !(r.op == op_io_rd || r.op == op_io_wr);
    i_n_mreq           <= !(r.op == op_mem_rd || r.op == op_mem_wr);
    i_frame_irq        <= r.irq;
    i_sprite_collision <= r.irq;
  endtask

  // Returns on the clock edge where the enable goes high
  task automatic wait_period_start();
    int n;
    n = 0;
    do begin
      @(posedge cpuClock);
      n++;
      if (n > 10) begin
        $display("Timeout: the CPU enable period never started");
        stop_on_error();
      end
    end while (en_phase != 3'd6);
  endtask

  task automatic wait_cpu_edge();
    int n;
    n = 0;
    do begin
      @(negedge cpuClock);
      n++;
      if (n > 4) begin
        $display("Timeout: the DUT never raised its CPU edge strobe");
        stop_on_error();
      end
    end while (!dut_i.u_decode.o_cpu_edge);
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("ERR %s row %0d got %h expected %h", name, row_idx, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_byte(string name, sms_pkg::byte_t got, sms_pkg::byte_t exp);
    if (got !== exp) begin
      $display("ERR %s row %0d got %h expected %h", name, row_idx, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_vdp_addr(string name, sms_pkg::vdp_addr_t got, sms_pkg::vdp_addr_t exp);
    if (got !== exp) begin
      $display("ERR %s row %0d got %h expected %h", name, row_idx, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_rom_addr(string name, sms_pkg::rom_addr_t got, sms_pkg::rom_addr_t exp);
    if (got !== exp) begin
      $display("ERR %s row %0d got %h expected %h", name, row_idx, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_ram_addr(string name, logic [ram_bits-1:0] got,
                                logic [ram_bits-1:0] exp);
    if (got !== exp) begin
      $display("ERR %s row %0d got %h expected %h", name, row_idx, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_mode(string name, sms_pkg::vdp_mode_t got, sms_pkg::vdp_mode_t exp);
    if (got !== exp) begin
      $display("ERR %s row %0d got %h expected %h", name, row_idx, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_strobes(row_t r, logic in_edge);
    check_bit("o_vdp_wr", o_vdp_wr, r.strb[0] && in_edge);
    check_bit("o_vdp_rd", o_vdp_rd, r.strb[1] && in_edge);
    check_bit("o_psg_we", o_psg_we, r.strb[2] && in_edge);
    check_bit("o_ram_we", o_ram_we, r.strb[3]);  // Lasts the whole write cycle
  endtask

  task automatic check_row(row_t r);
    case (r.chk)
      chk_data:     check_byte("o_cpu_data_in", o_cpu_data_in, r.exp[7:0]);
      chk_vaddr:    check_vdp_addr("o_vdp_addr", o_vdp_addr, r.exp[13:0]);
      chk_rom:      check_rom_addr("o_rom_addr", o_rom_addr, r.exp[21:0]);
      chk_ram:      check_ram_addr("o_ram_addr", o_ram_addr, r.exp[ram_bits-1:0]);
      chk_mode:     check_mode("o_mode", o_mode, r.exp[2:0]);
      chk_name:     check_vdp_addr("o_name_table_addr", o_name_table_addr, r.exp[13:0]);
      chk_color:    check_vdp_addr("o_color_table_addr", o_color_table_addr, r.exp[13:0]);
      chk_pattern:  check_vdp_addr("o_pattern_addr", o_pattern_addr, r.exp[13:0]);
      chk_sattr:    check_vdp_addr("o_sprite_attr_addr", o_sprite_attr_addr, r.exp[13:0]);
      chk_spat:     check_vdp_addr("o_sprite_pattern_addr", o_sprite_pattern_addr,
                                   r.exp[13:0]);
      chk_xscroll:  check_byte("o_x_scroll", o_x_scroll, r.exp[7:0]);
      chk_yscroll:  check_byte("o_y_scroll", o_y_scroll, r.exp[7:0]);
      chk_line:     check_byte("o_line_counter", o_line_counter, r.exp[7:0]);
      chk_overscan: check_byte("o_overscan_color", {4'd0, o_overscan_color}, r.exp[7:0]);
      chk_cram:     check_bit("o_cram_selected", o_cram_selected, r.exp[0]);
      chk_video_on: check_bit("o_video_on", o_video_on, r.exp[0]);
      chk_irq_en:   check_bit("o_frame_irq_en", o_frame_irq_en, r.exp[0]);
      default: ;
    endcase
  endtask

  initial begin
    void'($urandom(32'h391));
    n_hard_reset       = 1'b0;
    i_address          = 16'h0000;
    i_data             = 8'h00;
    i_n_rd             = 1'b1;
    i_n_wr             = 1'b1;
    i_n_mreq           = 1'b1;
    i_n_iorq           = 1'b1;
    i_frame_irq        = 1'b0;
    i_sprite_collision = 1'b0;
    i_too_many_sprites = 1'b0;
    i_bios_data        = 8'($urandom);
    i_rom_data         = 8'($urandom);
    i_ram_data         = 8'($urandom);
    i_vdp_rdata        = 8'($urandom);
    i_v_counter        = 8'($urandom);
    i_h_counter        = 8'($urandom);
    i_buttons          = 6'($urandom);
    i_sprite5          = 5'($urandom);
    build_table();
    repeat (4) @(posedge cpuClock);
    n_hard_reset <= 1'b1;
    for (row_idx = 0; row_idx < rows.size(); row_idx++) begin
      wait_period_start();
      drive_bus(rows[row_idx]);
      wait_cpu_edge();
      check_strobes(rows[row_idx], 1'b1);
      @(negedge cpuClock);  // Register writes visible from here
      check_row(rows[row_idx]);
      check_strobes(rows[row_idx], 1'b0);
    end
    $display("TEST PASSED");
    $finish;
  end

endmodule

//--- project.f
logic/sms_pkg.sv
logic/sms_bus_decode.sv
logic/sms_vdp_port.sv
logic/sms_mapper.sv
logic/sms_read_mux.sv
logic/sms_bus_top.sv
verification/sms_bus_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= sms_bus_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TEST PASSED" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
